//--- compile.f
+incdir+verification
src/demodPkg.sv
src/demodIfs.sv
src/demodRegs.sv
src/symbolDeskew.sv
src/fmDemod.sv
src/dacChannel.sv
src/hostReadMux.sv
src/demodTop.sv
verification/demodTb.sv

//--- src/dacChannel.sv
`timescale 1ns/10ps

module dacChannel import demodPkg::*; #(
    parameter int chanIdx = 0
) (
    input  logic                   clk,
    input  logic                   arstN,
    hostBus.chan                   host,
    sampleBus.dst                  det,
    output logic                   dacSync,
    output logic [sampleWidth-1:0] dacData,
    output dacSrcT                 srcReg,
    output logic [countWidth-1:0]  sampleCount
);

    // per channel address slot
    localparam logic [addrWidth-1:0] srcAddr =
        addrWidth'(dacSrcBase + chanIdx * dacStride);
    localparam logic [addrWidth-1:0] cntAddr =
        addrWidth'(dacCountBase + chanIdx * dacStride);
    // ch0 raw I, ch1 raw Q, the rest follow the mode
    localparam dacSrcT srcInit =
        (chanIdx == 0) ? SRC_I : ((chanIdx == 1) ? SRC_Q : SRC_AUTO);
    localparam int padWidth = sampleWidth - detWidth;

    dacSrcT                 autoSrc;
    dacSrcT                 effSrc;
    logic [sampleWidth-1:0] fmtData;
    logic                   srcWrite;
    logic                   cntClear;

    // auto source picks the natural output for the mode
    always_comb begin
        case (host.mode)
            MODE_AM, MODE_BPSK: autoSrc = SRC_MAG;
            MODE_PM:            autoSrc = SRC_PHASE;
            default:            autoSrc = SRC_FREQ;
        endcase
        effSrc = (srcReg == SRC_AUTO) ? autoSrc : srcReg;
    end

    // left justify into the 18 bit dac word
    always_comb begin
        case (effSrc)
            SRC_I:     fmtData = det.iSym;
            SRC_Q:     fmtData = det.qSym;
            // mag flipped to offset binary
            SRC_MAG:   fmtData = {~det.mag[detWidth], det.mag[detWidth-1:0],
                                  {(padWidth-1){1'b0}}};
            SRC_FREQ:  fmtData = {det.freq, {padWidth{1'b0}}};
            SRC_PHASE: fmtData = {det.phase, {padWidth{1'b0}}};
            default:   fmtData = '0;
        endcase
    end

    // source in lane 0, undefined codes ignored
    assign srcWrite = host.wrEn[0] && (host.addr == srcAddr) &&
                      (host.wrData[7:0] <= 8'(SRC_AUTO));
    // any lane clears the counter
    assign cntClear = (|host.wrEn) && (host.addr == cntAddr);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            srcReg      <= srcInit;
            dacSync     <= 1'b0;
            sampleCount <= '0;
        end else begin
            dacSync <= det.sync;
            if (srcWrite) begin
                srcReg <= dacSrcT'(host.wrData[2:0]);
            end
            // clear wins over a same cycle count
            if (cntClear) begin
                sampleCount <= '0;
            end else if (dacSync) begin
                sampleCount <= sampleCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (det.sync) begin
            dacData <= fmtData;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(srcReg) && (srcReg inside {SRC_I, SRC_Q, SRC_MAG,
        SRC_FREQ, SRC_PHASE, SRC_AUTO}))
        else $error("dacChannel %0d: illegal source %0d", chanIdx, srcReg);

endmodule

//--- src/demodIfs.sv
`timescale 1ns/10ps

// host register bus, writes only
// reads come back combinationally on the top level rdData
interface hostBus import demodPkg::*; ();

    logic [addrWidth-1:0]   addr;
    logic [dataWidth-1:0]   wrData;
    // one enable per byte lane
    logic [dataWidth/8-1:0] wrEn;
    // global mode, from the register block
    demodModeT              mode;

    modport master (output addr, output wrData, output wrEn, input mode);
    modport regs   (input addr, input wrData, input wrEn, output mode);
    modport chan   (input addr, input wrData, input wrEn, input mode);
    modport rd     (input addr);

endinterface

// symbol rate samples plus detector outputs
// sync is a single cycle strobe, data valid in that cycle
interface sampleBus import demodPkg::*; ();

    logic                          sync;
    logic signed [sampleWidth-1:0] iSym;
    logic signed [sampleWidth-1:0] qSym;
    logic [detWidth-1:0]           phase;
    logic [detWidth-1:0]           freq;
    // magnitude is one bit wider
    logic [detWidth:0]             mag;

    modport src (output sync, output iSym, output qSym,
                 output phase, output freq, output mag);
    modport dst (input sync, input iSym, input qSym,
                 input phase, input freq, input mag);

endinterface

//--- src/demodPkg.sv
package demodPkg;

    // demodulation modes as held in the mode register
    typedef enum logic [2:0] {
        MODE_AM    = 3'd0,
        MODE_FM    = 3'd1,
        MODE_PM    = 3'd2,
        MODE_FSK2  = 3'd3,
        MODE_BPSK  = 3'd4,
        MODE_QPSK  = 3'd5,
        MODE_OQPSK = 3'd6
    } demodModeT;

    // dac source select codes
    typedef enum logic [2:0] {
        SRC_I     = 3'd0,
        SRC_Q     = 3'd1,
        SRC_MAG   = 3'd2,
        SRC_FREQ  = 3'd3,
        SRC_PHASE = 3'd4,
        SRC_AUTO  = 3'd5
    } dacSrcT;

    // datapath widths
    localparam int sampleWidth  = 18;
    localparam int detWidth     = 8;
    localparam int cordicStages = 12;
    localparam int angleWidth   = 16;
    localparam int addrWidth    = 12;
    localparam int dataWidth    = 32;
    localparam int countWidth   = 16;

    // atan(2^-k), full turn = 65536
    localparam logic [angleWidth-1:0] atanTable [cordicStages] = '{
        16'd8192, 16'd4836, 16'd2555, 16'd1297,
        16'd651,  16'd326,  16'd163,  16'd81,
        16'd41,   16'd20,   16'd10,   16'd5
    };

    // host address map
    localparam logic [addrWidth-1:0] modeAddr     = 12'h000;
    localparam logic [addrWidth-1:0] dacSrcBase   = 12'h010;
    localparam logic [addrWidth-1:0] dacCountBase = 12'h014;
    localparam logic [addrWidth-1:0] dacStride    = 12'h008;

endpackage

//--- src/demodRegs.sv
`timescale 1ns/10ps

module demodRegs import demodPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    hostBus.regs                 host,
    output logic [dataWidth-1:0] rdData
);

    demodModeT modeReg;
    logic      modeHit;
    logic      modeLegal;

    // mode field sits in byte lane 0
    // upper lanes have no storage behind them
    assign modeHit = (host.addr == modeAddr) && host.wrEn[0];

    // codes past OQPSK leave the old mode in place
    assign modeLegal = (host.wrData[7:0] <= 8'(MODE_OQPSK));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            modeReg <= MODE_AM;
        end else if (modeHit && modeLegal) begin
            modeReg <= demodModeT'(host.wrData[2:0]);
        end
    end

    // mode fans out to deskew and dac channels
    assign host.mode = modeReg;

    // zero extended readback
    assign rdData = dataWidth'(modeReg);

    // mode register only ever holds a defined mode
    assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(modeReg) && (modeReg inside {MODE_AM, MODE_FM, MODE_PM,
        MODE_FSK2, MODE_BPSK, MODE_QPSK, MODE_OQPSK}))
        else $error("demodRegs: illegal mode %0d", modeReg);

endmodule

//--- src/demodTop.sv
`timescale 1ns/10ps

module demodTop import demodPkg::*; #(
    parameter int numDacs = 3
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          syncIn,
    input  logic signed [sampleWidth-1:0] iRx,
    input  logic signed [sampleWidth-1:0] qRx,
    input  logic [addrWidth-1:0]          addr,
    input  logic [dataWidth-1:0]          wrData,
    input  logic [dataWidth/8-1:0]        wrEn,
    output logic [dataWidth-1:0]          rdData,
    output logic [numDacs-1:0]            dacSync,
    output logic [sampleWidth-1:0]        dacData [numDacs]
);

    hostBus   hb ();
    // deskew to detector
    sampleBus symBus ();
    // detector to dac channels
    sampleBus detBus ();

    logic [dataWidth-1:0]  regsData;
    dacSrcT                srcRegs [numDacs];
    logic [countWidth-1:0] counts [numDacs];

    // host side of the bus comes straight from the pins
    assign hb.addr   = addr;
    assign hb.wrData = wrData;
    assign hb.wrEn   = wrEn;

    demodRegs uRegs (.clk(clk), .arstN(arstN), .host(hb), .rdData(regsData));

    symbolDeskew uDeskew (
        .clk(clk), .arstN(arstN), .syncIn(syncIn),
        .iIn(iRx), .qIn(qRx), .mode(hb.mode), .out(symBus)
    );

    fmDemod uDet (.clk(clk), .arstN(arstN), .in(symBus), .out(detBus));

    // identical channels, each at its own address slot
    for (genvar c = 0; c < numDacs; c++) begin : gDac
        dacChannel #(.chanIdx(c)) uDac (
            .clk(clk), .arstN(arstN), .host(hb), .det(detBus),
            .dacSync(dacSync[c]), .dacData(dacData[c]),
            .srcReg(srcRegs[c]), .sampleCount(counts[c])
        );
    end

    hostReadMux #(.numDacs(numDacs)) uRdMux (
        .addr(addr), .regsData(regsData),
        .srcRegs(srcRegs), .counts(counts), .rdData(rdData)
    );

    // end to end latency: deskew 1, cordic 12, detector out 1, dac 1
    assert property (@(posedge clk) disable iff (!arstN)
        syncIn |-> ##15 dacSync[0])
        else $error("demodTop: dacSync not 15 cycles after syncIn");

endmodule

//--- src/fmDemod.sv
`timescale 1ns/10ps

module fmDemod import demodPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    sampleBus.dst in,
    sampleBus.src out
);

    // two guard bits, cordic gain is about 1.65
    localparam int cw = sampleWidth + 2;

    typedef struct packed {
        logic signed [cw-1:0]  x;
        logic signed [cw-1:0]  y;
        logic [angleWidth-1:0] z;
    } cordicT;

    cordicT                        seed;
    cordicT                        stg [cordicStages];
    logic [cordicStages-1:0]       syncPipe;
    logic signed [sampleWidth-1:0] iDly [cordicStages];
    logic signed [sampleWidth-1:0] qDly [cordicStages];
    logic                          syncOut;
    logic [detWidth-1:0]           phaseNew;
    logic [detWidth-1:0]           phaseOut;
    logic [detWidth-1:0]           freqOut;
    logic [detWidth:0]             magOut;
    logic signed [sampleWidth-1:0] iOut;
    logic signed [sampleWidth-1:0] qOut;

    // one vectoring step, drives y toward zero
    function automatic cordicT rotate(cordicT v, int k);
        cordicT r;
        if (v.y < 0) begin
            // below the axis, turn counterclockwise
            r.x = v.x - (v.y >>> k);
            r.y = v.y + (v.x >>> k);
            r.z = v.z - atanTable[k];
        end else begin
            r.x = v.x + (v.y >>> k);
            r.y = v.y - (v.x >>> k);
            r.z = v.z + atanTable[k];
        end
        return r;
    endfunction

    // left half plane: flip by a half turn so the cordic converges
    always_comb begin
        if (in.iSym < 0) begin
            seed.x = -in.iSym;
            seed.y = -in.qSym;
            seed.z = 16'h8000;
        end else begin
            seed.x = in.iSym;
            seed.y = in.qSym;
            seed.z = '0;
        end
    end

    // free running pipe, sync marks the live slots
    always_ff @(posedge clk) begin
        stg[0]  <= rotate(seed, 0);
        iDly[0] <= in.iSym;
        qDly[0] <= in.qSym;
        for (int k = 1; k < cordicStages; k++) begin
            stg[k]  <= rotate(stg[k-1], k);
            iDly[k] <= iDly[k-1];
            qDly[k] <= qDly[k-1];
        end
    end

    // phase = top byte of the angle
    assign phaseNew = stg[cordicStages-1].z[angleWidth-1 -: detWidth];

    // phaseOut is the differentiator memory
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncPipe <= '0;
            syncOut  <= 1'b0;
            phaseOut <= '0;
        end else begin
            syncPipe <= {syncPipe[cordicStages-2:0], in.sync};
            syncOut  <= syncPipe[cordicStages-1];
            if (syncPipe[cordicStages-1]) begin
                phaseOut <= phaseNew;
            end
        end
    end

    // output stage, held between strobes
    always_ff @(posedge clk) begin
        if (syncPipe[cordicStages-1]) begin
            // wraps mod 256
            freqOut <= phaseNew - phaseOut;
            // bits 18:10 of x
            magOut  <= stg[cordicStages-1].x[cw-2 -: detWidth+1];
            iOut    <= iDly[cordicStages-1];
            qOut    <= qDly[cordicStages-1];
        end
    end

    assign out.sync  = syncOut;
    assign out.iSym  = iOut;
    assign out.qSym  = qOut;
    assign out.phase = phaseOut;
    assign out.freq  = freqOut;
    assign out.mag   = magOut;

    assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown({syncPipe, syncOut}))
        else $error("fmDemod: unknown sync in pipeline");

endmodule

//--- src/hostReadMux.sv
`timescale 1ns/10ps

module hostReadMux import demodPkg::*; #(
    parameter int numDacs = 3
) (
    input  logic [addrWidth-1:0]  addr,
    input  logic [dataWidth-1:0]  regsData,
    input  dacSrcT                srcRegs [numDacs],
    input  logic [countWidth-1:0] counts [numDacs],
    output logic [dataWidth-1:0]  rdData
);

    // pure decode of the address
    // unmapped space reads zero
    always_comb begin
        rdData = '0;
        if (addr == modeAddr) begin
            rdData = regsData;
        end
        // channel c sits at base + c * stride
        for (int c = 0; c < numDacs; c++) begin
            if (addr == addrWidth'(dacSrcBase + c * dacStride)) begin
                rdData = dataWidth'(srcRegs[c]);
            end
            if (addr == addrWidth'(dacCountBase + c * dacStride)) begin
                rdData = dataWidth'(counts[c]);
            end
        end
    end

endmodule

//--- src/symbolDeskew.sv
`timescale 1ns/10ps

module symbolDeskew import demodPkg::*; (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          syncIn,
    input  logic signed [sampleWidth-1:0] iIn,
    input  logic signed [sampleWidth-1:0] qIn,
    input  demodModeT                     mode,
    sampleBus.src                         out
);

    logic                          syncReg;
    logic signed [sampleWidth-1:0] iReg;
    logic signed [sampleWidth-1:0] qReg;
    // q from the previous strobe
    logic signed [sampleWidth-1:0] qDelay;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncReg <= 1'b0;
        end else begin
            syncReg <= syncIn;
        end
    end

    // sample registers, advance on strobe only
    always_ff @(posedge clk) begin
        if (syncIn) begin
            iReg   <= iIn;
            qDelay <= qIn;
            // oqpsk: q lags i by half a symbol, pull it back one sample
            qReg   <= (mode == MODE_OQPSK) ? qDelay : qIn;
        end
    end

    assign out.sync  = syncReg;
    assign out.iSym  = iReg;
    assign out.qSym  = qReg;
    // detector fields are filled in by fmDemod
    assign out.phase = '0;
    assign out.freq  = '0;
    assign out.mag   = '0;

endmodule

//--- verification/demodTbModel.svh
`ifndef DEMOD_TB_MODEL_SVH
`define DEMOD_TB_MODEL_SVH

// atan(2^-k) in angle units, full turn = 65536, rounded
function automatic int atanRef(input int k);
    real ang;
    ang = $atan(2.0 ** (-k));
    return $rtoi(ang / (2.0 * 3.14159265358979) * 65536.0 + 0.5);
endfunction

// vectoring cordic on plain ints
// phase is the top angle byte, mag is bits 18:10 of final x
function automatic void cordicRef(input int i, input int q,
                                  output logic [7:0] phase, output logic [8:0] mag);
    int x;
    int y;
    int z;
    int xn;
    int yn;
    // left half plane starts half a turn round
    if (i < 0) begin
        x = -i;
        y = -q;
        z = 32768;
    end else begin
        x = i;
        y = q;
        z = 0;
    end
    for (int k = 0; k < cordicStages; k++) begin
        if (y < 0) begin
            xn = x - (y >>> k);
            yn = y + (x >>> k);
            z  = z - atanRef(k);
        end else begin
            xn = x + (y >>> k);
            yn = y - (x >>> k);
            z  = z + atanRef(k);
        end
        x = xn;
        y = yn;
    end
    z = z & 32'hFFFF;
    phase = 8'(z >> 8);
    mag = 9'(x >>> 10);
endfunction

// source that SRC_AUTO resolves to
function automatic dacSrcT autoSrcRef(input demodModeT m);
    case (m)
        MODE_AM, MODE_BPSK: return SRC_MAG;
        MODE_PM:            return SRC_PHASE;
        default:            return SRC_FREQ;
    endcase
endfunction

// 18 bit dac word for one source
function automatic logic [17:0] dacRef(input dacSrcT src, input logic [17:0] i,
                                       input logic [17:0] q, input logic [8:0] mag,
                                       input logic [7:0] freq, input logic [7:0] phase);
    case (src)
        SRC_I:     return i;
        SRC_Q:     return q;
        // offset binary magnitude
        SRC_MAG:   return {~mag[8], mag[7:0], 9'b0};
        SRC_FREQ:  return {freq, 10'b0};
        SRC_PHASE: return {phase, 10'b0};
        default:   return 18'b0;
    endcase
endfunction

`endif

//--- verification/demodTb.sv
`timescale 1ns/10ps

module demodTb import demodPkg::*; ();

    `include "demodTbModel.svh"

    localparam int numDacs = 3;
    // strobes per test
    localparam int numBurst = 20;
    localparam int numSparse = 10;
    localparam int numRand = 24;
    localparam int numSkew = 16;
    localparam int numExplicit = 16;
    localparam int numCount = 10;
    localparam int totalStrobes = numBurst + numSparse + 3 * numRand + 2 * numSkew +
                                  3 * numExplicit + numCount;
    localparam int timeoutLimit = totalStrobes * 2 + 500;

    logic                          clk;
    logic                          arstN;
    logic                          syncIn;
    logic signed [sampleWidth-1:0] iRx;
    logic signed [sampleWidth-1:0] qRx;
    logic [addrWidth-1:0]          addr;
    logic [dataWidth-1:0]          wrData;
    logic [dataWidth/8-1:0]        wrEn;
    logic [dataWidth-1:0]          rdData;
    logic [numDacs-1:0]            dacSync;
    logic [sampleWidth-1:0]        dacData [numDacs];

    // scoreboard
    logic [sampleWidth-1:0] expQ [numDacs][$];
    int                     stampQ [numDacs][$];
    logic [sampleWidth-1:0] expData;
    int                     stamp;
    // model state
    demodModeT                     curMode = MODE_AM;
    dacSrcT                        curSrc [numDacs];
    logic signed [sampleWidth-1:0] prevQ = '0;
    logic [7:0]                    prevPhase = '0;
    integer                        seed = 48339;
    int                            cycles = 0;
    int                            checks = 0;
    int                            errors = 0;
    int                            testChecks;
    int                            testErrors;
    string                         testName = "reset";

    demodTop #(.numDacs(numDacs)) UUT (
        .clk(clk), .arstN(arstN), .syncIn(syncIn), .iRx(iRx), .qRx(qRx),
        .addr(addr), .wrData(wrData), .wrEn(wrEn), .rdData(rdData),
        .dacSync(dacSync), .dacData(dacData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeoutLimit) begin
            $display("timeout: run still busy after %0d cycles", timeoutLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
        checks++;
        testChecks++;
        assert (got === exp) else begin
            $display("CHECK FAILED %s %s: expected %0h, actual %0h", testName, what, exp, got);
            errors++;
            testErrors++;
        end
    endtask

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        if (arstN) begin
            if (syncIn) begin
                for (int c = 0; c < numDacs; c++) begin
                    stampQ[c].push_back(cycles);
                end
            end
            for (int c = 0; c < numDacs; c++) begin
                if (dacSync[c] && expQ[c].size() == 0) begin
                    $display("channel %0d put out a sample nobody sent (%s)", c, testName);
                    errors++;
                    testErrors++;
                end else if (dacSync[c]) begin
                    expData = expQ[c].pop_front();
                    checkValue($sformatf("ch%0d data", c), 32'(expData), 32'(dacData[c]));
                end
                // each channel keeps its own strobe stamps
                if (dacSync[c] && stampQ[c].size() != 0) begin
                    stamp = stampQ[c].pop_front();
                    checkValue($sformatf("ch%0d latency", c), 32'd15, 32'(cycles - stamp));
                end
            end
        end
    end

    function automatic int pending();
        int n;
        n = 0;
        for (int c = 0; c < numDacs; c++) begin
            n += expQ[c].size() + stampQ[c].size();
        end
        return n;
    endfunction

    function automatic dacSrcT effSrc(input int c);
        return (curSrc[c] == SRC_AUTO) ? autoSrcRef(curMode) : curSrc[c];
    endfunction

    task automatic writeReg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] be);
        @(posedge clk);
        addr <= a;
        wrData <= d;
        wrEn <= be;
        @(posedge clk);
        wrEn <= 4'h0;
    endtask

    task automatic readCheck(input logic [11:0] a, input logic [31:0] exp, input string what);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        checkValue(what, exp, rdData);
    endtask

    task automatic setMode(input demodModeT m);
        writeReg(modeAddr, 32'(m), 4'b0001);
        curMode = m;
    endtask

    task automatic setSource(input int c, input dacSrcT s);
        writeReg(12'(dacSrcBase + c * dacStride), 32'(s), 4'b0001);
        curSrc[c] = s;
        readCheck(12'(dacSrcBase + c * dacStride), 32'(s), $sformatf("ch%0d src", c));
    endtask

    // expected words are queued before the strobe goes out
    task automatic sendSample(input logic signed [17:0] i, input logic signed [17:0] q);
        logic signed [17:0] qEff;
        logic [7:0]         ph;
        logic [8:0]         mg;
        logic [7:0]         fr;
        qEff = (curMode == MODE_OQPSK) ? prevQ : q;
        prevQ = q;
        cordicRef(i, qEff, ph, mg);
        fr = ph - prevPhase;
        prevPhase = ph;
        for (int c = 0; c < numDacs; c++) begin
            expQ[c].push_back(dacRef(effSrc(c), i, qEff, mg, fr, ph));
        end
        @(posedge clk);
        syncIn <= 1'b1;
        iRx <= i;
        qRx <= q;
    endtask

    task automatic sendRandom();
        sendSample(18'($random(seed)), 18'($random(seed)));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            syncIn <= 1'b0;
        end
    endtask

    // stop strobing and let the pipe empty and the counters settle
    task automatic drain();
        idle(1);
        while (pending() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic startTest(input string name);
        testName = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic finishTest();
        $display("test %s done: %0d checks, %0d errors", testName, testChecks, testErrors);
    endtask

    initial begin
        int gap;
        syncIn = 1'b0;
        iRx = '0;
        qRx = '0;
        addr = '0;
        wrData = '0;
        wrEn = '0;
        arstN = 1'b0;
        curSrc[0] = SRC_I;
        curSrc[1] = SRC_Q;
        for (int c = 2; c < numDacs; c++) begin
            curSrc[c] = SRC_AUTO;
        end
        repeat (3) @(posedge clk);
        arstN <= 1'b1;

        startTest("regs");
        readCheck(modeAddr, 32'(MODE_AM), "mode reset");
        for (int c = 0; c < numDacs; c++) begin
            readCheck(12'(dacSrcBase + c * dacStride), 32'(curSrc[c]), "src reset");
            readCheck(12'(dacCountBase + c * dacStride), 32'd0, "count reset");
        end
        // mode holds with lane 0 disabled
        writeReg(modeAddr, 32'h0000_0202, 4'b1110);
        readCheck(modeAddr, 32'(MODE_AM), "mode lane0 off");
        writeReg(modeAddr, 32'hFFFF_FF01, 4'b0001);
        readCheck(modeAddr, 32'(MODE_FM), "mode lane0 on");
        writeReg(12'h020, 32'h0000_0003, 4'b1110);
        readCheck(12'h020, 32'(SRC_AUTO), "ch2 src lane0 off");
        setSource(2, SRC_PHASE);
        setSource(2, SRC_AUTO);
        readCheck(12'h004, 32'd0, "unmapped 004");
        readCheck(12'h100, 32'd0, "unmapped 100");
        readCheck(12'hFFC, 32'd0, "unmapped ffc");
        setMode(MODE_AM);
        finishTest();

        startTest("rawIQ");
        repeat (numBurst) sendRandom();
        drain();
        // sparse strobes with random gaps
        repeat (numSparse) begin
            sendRandom();
            gap = 1 + ({$random(seed)} % 4);
            idle(gap);
        end
        drain();
        finishTest();

        startTest("autoSrc");
        setMode(MODE_AM);
        repeat (numRand) sendRandom();
        drain();
        setMode(MODE_FM);
        repeat (numRand) sendRandom();
        drain();
        setMode(MODE_PM);
        repeat (numRand) sendRandom();
        drain();
        finishTest();

        // ch1 still on raw Q
        startTest("oqpsk");
        setMode(MODE_OQPSK);
        repeat (numSkew) sendRandom();
        drain();
        setMode(MODE_QPSK);
        repeat (numSkew) sendRandom();
        drain();
        finishTest();

        startTest("explicit");
        setMode(MODE_BPSK);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < numDacs; c++) begin
                case ((c + r) % 3)
                    0: setSource(c, SRC_MAG);
                    1: setSource(c, SRC_PHASE);
                    default: setSource(c, SRC_FREQ);
                endcase
            end
            repeat (numExplicit) sendRandom();
            drain();
        end
        finishTest();

        startTest("counters");
        // any byte lane clears
        for (int c = 0; c < numDacs; c++) begin
            writeReg(12'(dacCountBase + c * dacStride), 32'h0, 4'(1 << (c % 4)));
            readCheck(12'(dacCountBase + c * dacStride), 32'd0, "count cleared");
        end
        repeat (numCount) sendRandom();
        drain();
        for (int c = 0; c < numDacs; c++) begin
            readCheck(12'(dacCountBase + c * dacStride), 32'(numCount), "count");
        end
        writeReg(12'(dacCountBase + dacStride), 32'h0, 4'b0010);
        readCheck(12'(dacCountBase + dacStride), 32'd0, "ch1 count cleared");
        readCheck(dacCountBase, 32'(numCount), "ch0 count kept");
        readCheck(12'(dacCountBase + 2 * dacStride), 32'(numCount), "ch2 count kept");
        finishTest();

        assert (pending() == 0) else begin
            $display("%0d expected outputs never came out", pending());
            errors++;
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
